// ==== logic/proc_cfg.svh ====
// Core configuration for the 16-bit pipelined processor
// Data width, register count and data memory size

`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// Data and instruction word width
`define PROC_XLEN 16
// Architectural registers
`define PROC_NREGS 8
// Data memory word-address bits, addresses wrap at this width
`define PROC_DMEM_AW 8

`endif

// ==== logic/proc_pkg.sv ====
// Shared types for the pipelined core
// Opcodes, instruction formats, ALU and control encodings

`include "proc_cfg.svh"

package proc_pkg;

   typedef logic [$clog2(`PROC_NREGS)-1:0] regIdxT;

   typedef enum logic [4:0] {
      OP_HALT = 5'b00000,
      OP_NOP  = 5'b00001,
      OP_ADDI = 5'b01000,
      OP_BEQZ = 5'b01100,
      OP_BNEZ = 5'b01101,
      OP_ST   = 5'b10000,
      OP_LD   = 5'b10001,
      OP_LBI  = 5'b11000,
      OP_ALU  = 5'b11011
   } opcodeE;

   // Function field of the register format, SUB is rs minus rt
   typedef enum logic [1:0] {FN_ADD, FN_SUB, FN_XOR, FN_AND} funcE;

   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_PASSB} aluOpE;
   typedef enum logic {WB_ALU, WB_MEM} wbSelE;
   typedef enum logic [1:0] {BR_NONE, BR_EQZ, BR_NEZ} brTypeE;

   typedef struct packed {
      opcodeE opcode;
      regIdxT rs;
      regIdxT rt;
      regIdxT rd;
      funcE   func;
   } rFmtS;

   // ST takes its store data from rd
   typedef struct packed {
      opcodeE     opcode;
      regIdxT     rs;
      regIdxT     rd;
      logic [4:0] imm;
   } iFmtS;

   typedef struct packed {
      opcodeE     opcode;
      regIdxT     rs;
      logic [7:0] imm;
   } bFmtS;

   typedef union packed {
      rFmtS r;
      iFmtS i;
      bFmtS b;
   } instrU;

   typedef struct packed {
      aluOpE  aluOp;
      logic   immSel;
      logic   memRd;
      logic   memWr;
      brTypeE brType;
      logic   regWr;
      regIdxT rd;
      wbSelE  wbSel;
      logic   halt;
      logic   illegal;
      logic   valid;
   } ctrlS;

endpackage

// ==== logic/proc_if.sv ====
// Stage-to-stage bundles of the pipelined core
// Decode to execute, execute to memory, and the writeback path

`include "proc_cfg.svh"

interface decExIf;
   proc_pkg::ctrlS        ctrl;
   logic [`PROC_XLEN-1:0] opA;
   logic [`PROC_XLEN-1:0] opB;
   logic [`PROC_XLEN-1:0] stData;
   logic [`PROC_XLEN-1:0] imm;
   proc_pkg::regIdxT      srcA;
   proc_pkg::regIdxT      srcB;
   proc_pkg::regIdxT      srcS;
   logic [`PROC_XLEN-1:0] nextPc;

   modport producer (output ctrl, opA, opB, stData, imm, srcA, srcB, srcS, nextPc);
   modport consumer (input ctrl, opA, opB, stData, imm, srcA, srcB, srcS, nextPc);
endinterface

interface exMemIf;
   proc_pkg::ctrlS        ctrl;
   logic [`PROC_XLEN-1:0] aluResult;
   logic [`PROC_XLEN-1:0] stData;

   modport producer (output ctrl, aluResult, stData);
   modport consumer (input ctrl, aluResult, stData);
endinterface

// Instruction leaving the pipeline, read by decode and execute
interface wbIf;
   logic                  valid;
   logic                  regWr;
   proc_pkg::regIdxT      rd;
   logic [`PROC_XLEN-1:0] data;

   modport producer (output valid, regWr, rd, data);
   modport consumer (input valid, regWr, rd, data);
endinterface

// ==== logic/fetch.sv ====
// Fetch stage
// Program counter and the fetch/decode register, with stall hold,
// branch redirect and stop after halt

`include "proc_cfg.svh"

module fetch (
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  stall,
   input  logic                  redirect,
   input  logic [`PROC_XLEN-1:0] redirectPc,
   input  logic                  haltSeen,
   output logic [`PROC_XLEN-1:0] imemAddr,
   input  logic [`PROC_XLEN-1:0] imemData,
   output proc_pkg::instrU       instrD,
   output logic [`PROC_XLEN-1:0] nextPcD,
   output logic                  validD
);

   logic [`PROC_XLEN-1:0] pc;
   logic [`PROC_XLEN-1:0] pcPlus1;
   logic                  advance;

   assign imemAddr = pc;
   assign pcPlus1  = pc + 1'b1;
   assign advance  = !haltSeen && !redirect && !stall;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc     <= '0;
         validD <= 1'b0;
      end else if (haltSeen) begin
         validD <= 1'b0;
      end else if (redirect) begin
         // Word being fetched is on the wrong path
         pc     <= redirectPc;
         validD <= 1'b0;
      end else if (!stall) begin
         pc     <= pcPlus1;
         validD <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         instrD  <= imemData;
         nextPcD <= pcPlus1;
      end
   end

endmodule

// ==== logic/decode.sv ====
// Decode stage
// Control decode, register file with writeback bypass, load-use stall
// and the decode/execute pipeline register

`include "proc_cfg.svh"

module decode (
   input  logic                  clk,
   input  logic                  rstN,
   input  proc_pkg::instrU       instrD,
   input  logic [`PROC_XLEN-1:0] nextPcD,
   input  logic                  validD,
   input  logic                  redirect,
   wbIf.consumer                 wb,
   decExIf.producer              de,
   input  logic                  exMemLoad,
   output logic                  stall
);

   logic [`PROC_XLEN-1:0] regs [`PROC_NREGS];
   proc_pkg::ctrlS        ctrl;
   proc_pkg::regIdxT      srcA;
   proc_pkg::regIdxT      srcB;
   proc_pkg::regIdxT      srcS;
   logic [`PROC_XLEN-1:0] immI;
   logic [`PROC_XLEN-1:0] immB;
   logic [`PROC_XLEN-1:0] imm;
   logic [`PROC_XLEN-1:0] regA;
   logic [`PROC_XLEN-1:0] regB;
   logic [`PROC_XLEN-1:0] regS;
   logic                  usesA;
   logic                  usesB;
   logic                  usesS;
   logic                  wbWrite;
   logic                  loadHit;

   // Same word seen through the three formats
   assign srcA = instrD.r.rs;
   assign srcB = instrD.r.rt;
   assign srcS = instrD.i.rd;
   assign immI = {{(`PROC_XLEN-5){instrD.i.imm[4]}}, instrD.i.imm};
   assign immB = {{(`PROC_XLEN-8){instrD.b.imm[7]}}, instrD.b.imm};

   always_comb begin
      ctrl       = '0;
      ctrl.valid = validD;
      imm        = immI;
      usesA      = 1'b0;
      usesB      = 1'b0;
      usesS      = 1'b0;
      case (instrD.r.opcode)
         proc_pkg::OP_ALU: begin
            case (instrD.r.func)
               proc_pkg::FN_ADD: ctrl.aluOp = proc_pkg::ALU_ADD;
               proc_pkg::FN_SUB: ctrl.aluOp = proc_pkg::ALU_SUB;
               proc_pkg::FN_XOR: ctrl.aluOp = proc_pkg::ALU_XOR;
               default:          ctrl.aluOp = proc_pkg::ALU_AND;
            endcase
            ctrl.regWr = 1'b1;
            ctrl.rd    = instrD.r.rd;
            usesA      = 1'b1;
            usesB      = 1'b1;
         end
         proc_pkg::OP_ADDI, proc_pkg::OP_LD: begin
            ctrl.immSel = 1'b1;
            ctrl.regWr  = 1'b1;
            ctrl.rd     = instrD.i.rd;
            ctrl.memRd  = (instrD.r.opcode == proc_pkg::OP_LD);
            ctrl.wbSel  = ctrl.memRd ? proc_pkg::WB_MEM : proc_pkg::WB_ALU;
            usesA       = 1'b1;
         end
         proc_pkg::OP_ST: begin
            ctrl.immSel = 1'b1;
            ctrl.memWr  = 1'b1;
            usesA       = 1'b1;
            usesS       = 1'b1;
         end
         proc_pkg::OP_LBI: begin
            ctrl.aluOp  = proc_pkg::ALU_PASSB;
            ctrl.immSel = 1'b1;
            ctrl.regWr  = 1'b1;
            ctrl.rd     = instrD.b.rs;
            imm         = immB;
         end
         proc_pkg::OP_BEQZ, proc_pkg::OP_BNEZ: begin
            ctrl.brType = (instrD.r.opcode == proc_pkg::OP_BEQZ) ?
                          proc_pkg::BR_EQZ : proc_pkg::BR_NEZ;
            imm         = immB;
            usesA       = 1'b1;
         end
         proc_pkg::OP_NOP: ;
         proc_pkg::OP_HALT: ctrl.halt = 1'b1;
         default: ctrl.illegal = 1'b1;
      endcase
   end

   // Register reads see the write retiring this cycle
   assign wbWrite = wb.valid && wb.regWr;
   assign regA    = (wbWrite && wb.rd == srcA) ? wb.data : regs[srcA];
   assign regB    = (wbWrite && wb.rd == srcB) ? wb.data : regs[srcB];
   assign regS    = (wbWrite && wb.rd == srcS) ? wb.data : regs[srcS];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int k = 0; k < `PROC_NREGS; k++) begin
            regs[k] <= '0;
         end
      end else if (wbWrite) begin
         regs[wb.rd] <= wb.data;
      end
   end

   // Load in execute feeding this instruction
   assign loadHit = (usesA && de.ctrl.rd == srcA) || (usesB && de.ctrl.rd == srcB) ||
                    (usesS && de.ctrl.rd == srcS);
   assign stall   = validD && exMemLoad && loadHit;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         de.ctrl <= '0;
      end else if (stall || redirect) begin
         de.ctrl <= '0;
      end else begin
         de.ctrl <= ctrl;
      end
   end

   always_ff @(posedge clk) begin
      de.opA    <= regA;
      de.opB    <= regB;
      de.stData <= regS;
      de.imm    <= imm;
      de.srcA   <= srcA;
      de.srcB   <= srcB;
      de.srcS   <= srcS;
      de.nextPc <= nextPcD;
   end

endmodule

// ==== logic/execute.sv ====
// Execute stage
// Operand forwarding, ALU, branch resolution and the
// execute/memory pipeline register

`include "proc_cfg.svh"

module execute (
   input  logic                  clk,
   input  logic                  rstN,
   decExIf.consumer              de,
   exMemIf.producer              xm,
   wbIf.consumer                 wb,
   output logic                  redirect,
   output logic [`PROC_XLEN-1:0] redirectPc
);

   logic                  memFwdOk;
   logic                  wbFwdOk;
   logic [`PROC_XLEN-1:0] fwdA;
   logic [`PROC_XLEN-1:0] fwdB;
   logic [`PROC_XLEN-1:0] fwdS;
   logic [`PROC_XLEN-1:0] aluB;
   logic [`PROC_XLEN-1:0] aluOut;
   logic                  isZero;

   // A load in memory has no data yet, the load-use stall covers it
   assign memFwdOk = xm.ctrl.valid && xm.ctrl.regWr && xm.ctrl.wbSel == proc_pkg::WB_ALU;
   assign wbFwdOk  = wb.valid && wb.regWr;

   // Memory stage is younger than writeback and wins
   assign fwdA = (memFwdOk && xm.ctrl.rd == de.srcA) ? xm.aluResult :
                 (wbFwdOk && wb.rd == de.srcA) ? wb.data : de.opA;
   assign fwdB = (memFwdOk && xm.ctrl.rd == de.srcB) ? xm.aluResult :
                 (wbFwdOk && wb.rd == de.srcB) ? wb.data : de.opB;
   assign fwdS = (memFwdOk && xm.ctrl.rd == de.srcS) ? xm.aluResult :
                 (wbFwdOk && wb.rd == de.srcS) ? wb.data : de.stData;

   assign aluB = de.ctrl.immSel ? de.imm : fwdB;

   always_comb begin
      case (de.ctrl.aluOp)
         proc_pkg::ALU_ADD: aluOut = fwdA + aluB;
         proc_pkg::ALU_SUB: aluOut = fwdA - aluB;
         proc_pkg::ALU_AND: aluOut = fwdA & aluB;
         proc_pkg::ALU_XOR: aluOut = fwdA ^ aluB;
         default:           aluOut = aluB;
      endcase
   end

   // Branch on the forwarded rs, target relative to the next PC
   assign isZero     = (fwdA == '0);
   assign redirect   = de.ctrl.valid &&
                       ((de.ctrl.brType == proc_pkg::BR_EQZ && isZero) ||
                        (de.ctrl.brType == proc_pkg::BR_NEZ && !isZero));
   assign redirectPc = de.nextPc + de.imm;

   // The branch itself moves on, its younger instructions die in fetch and decode
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         xm.ctrl <= '0;
      end else begin
         xm.ctrl <= de.ctrl;
      end
   end

   always_ff @(posedge clk) begin
      xm.aluResult <= aluOut;
      xm.stData    <= fwdS;
   end

endmodule

// ==== logic/memory.sv ====
// Memory stage
// Data memory, writeback select and the memory/writeback register,
// with the sticky halt and err levels

`include "proc_cfg.svh"

module memory (
   input  logic     clk,
   input  logic     rstN,
   exMemIf.consumer xm,
   wbIf.producer    wb,
   output logic     halt,
   output logic     err
);

   logic [`PROC_XLEN-1:0]    dmem [2**`PROC_DMEM_AW];
   logic [`PROC_DMEM_AW-1:0] addr;
   logic [`PROC_XLEN-1:0]    rdData;
   logic                     retireOk;

   assign addr     = xm.aluResult[`PROC_DMEM_AW-1:0];
   assign rdData   = dmem[addr];
   // Nothing behind a halt or illegal instruction takes effect
   assign retireOk = xm.ctrl.valid && !halt && !err;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int k = 0; k < 2**`PROC_DMEM_AW; k++) begin
            dmem[k] <= '0;
         end
      end else if (retireOk && xm.ctrl.memWr) begin
         dmem[addr] <= xm.stData;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         wb.valid <= 1'b0;
         wb.regWr <= 1'b0;
         halt     <= 1'b0;
         err      <= 1'b0;
      end else begin
         wb.valid <= retireOk;
         wb.regWr <= retireOk && xm.ctrl.regWr;
         halt     <= halt || (retireOk && xm.ctrl.halt);
         err      <= err || (retireOk && xm.ctrl.illegal);
      end
   end

   always_ff @(posedge clk) begin
      wb.rd   <= xm.ctrl.rd;
      wb.data <= (xm.ctrl.wbSel == proc_pkg::WB_MEM) ? rdData : xm.aluResult;
   end

endmodule

// ==== logic/proc.sv ====
// Five-stage 16-bit pipelined processor core
// Fetch, decode, execute, memory and writeback, with forwarding,
// load-use stall and branch flush; retire trace on the wb outputs

`include "proc_cfg.svh"

module proc (
   input  logic                             clk,
   input  logic                             rstN,
   output logic [`PROC_XLEN-1:0]            imemAddr,
   input  logic [`PROC_XLEN-1:0]            imemData,
   output logic                             wbValid,
   output logic [$clog2(`PROC_NREGS)-1:0]   wbReg,
   output logic [`PROC_XLEN-1:0]            wbData,
   output logic                             halt,
   output logic                             err
);

   logic                  stall;
   logic                  redirect;
   logic [`PROC_XLEN-1:0] redirectPc;
   logic                  haltSeen;
   logic                  exMemLoad;
   proc_pkg::instrU       instrD;
   logic [`PROC_XLEN-1:0] nextPcD;
   logic                  validD;

   decExIf deBus ();
   exMemIf xmBus ();
   wbIf    wbBus ();

   // A load sitting in execute, checked by decode for load-use
   assign exMemLoad = deBus.ctrl.valid && deBus.ctrl.memRd;
   assign haltSeen  = halt || err;

   fetch fetchInst (
      .clk        (clk),
      .rstN       (rstN),
      .stall      (stall),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .haltSeen   (haltSeen),
      .imemAddr   (imemAddr),
      .imemData   (imemData),
      .instrD     (instrD),
      .nextPcD    (nextPcD),
      .validD     (validD)
   );

   decode decodeInst (
      .clk       (clk),
      .rstN      (rstN),
      .instrD    (instrD),
      .nextPcD   (nextPcD),
      .validD    (validD),
      .redirect  (redirect),
      .wb        (wbBus.consumer),
      .de        (deBus.producer),
      .exMemLoad (exMemLoad),
      .stall     (stall)
   );

   execute executeInst (
      .clk        (clk),
      .rstN       (rstN),
      .de         (deBus.consumer),
      .xm         (xmBus.producer),
      .wb         (wbBus.consumer),
      .redirect   (redirect),
      .redirectPc (redirectPc)
   );

   memory memoryInst (
      .clk  (clk),
      .rstN (rstN),
      .xm   (xmBus.consumer),
      .wb   (wbBus.producer),
      .halt (halt),
      .err  (err)
   );

   // Retire trace, only register writes strobe
   assign wbValid = wbBus.valid && wbBus.regWr;
   assign wbReg   = wbBus.rd;
   assign wbData  = wbBus.data;

endmodule

// ==== verif/proc_sva.sv ====
// Status checks for the pipelined core
// Retire strobe after halt, sticky halt and err, clean state after reset

module proc_sva (
   input logic clk,
   input logic rstN,
   input logic wbValid,
   input logic halt,
   input logic err
);
   timeunit 1ns;
   timeprecision 100ps;

   int failCount = 0;

   noRetireAfterStop: assert property (@(posedge clk) disable iff (!rstN)
      (halt || err) |-> !wbValid)
      else begin
         $error("Retire strobe seen while the core is halted");
         failCount++;
      end

   haltSticky: assert property (@(posedge clk) disable iff (!rstN) halt |=> halt)
      else begin
         $error("halt fell without a reset");
         failCount++;
      end

   errSticky: assert property (@(posedge clk) disable iff (!rstN) err |=> err)
      else begin
         $error("err fell without a reset");
         failCount++;
      end

   // First cycle out of reset
   cleanAfterReset: assert property (@(posedge clk)
      $rose(rstN) |-> (!wbValid && !halt && !err))
      else begin
         $error("Status outputs not low right after reset");
         failCount++;
      end

endmodule

// ==== verif/proc_tb.sv ====
// Testbench for the pipelined core
// Random programs run on the DUT and on an architectural model
// Retire trace and the halt and err levels are compared

`include "proc_cfg.svh"

module proc_tb;
   timeunit 1ns;
   timeprecision 100ps;

   typedef logic [`PROC_XLEN-1:0] wordT;

   localparam int   ProgLen       = 64;
   localparam int   ClkPeriod     = 10;
   localparam int   Runs          = 2;
   localparam int   TimeoutCycles = Runs * 20 * ProgLen;
   localparam wordT NopWord       = {proc_pkg::OP_NOP, 11'b0};

   logic             clk;
   logic             rstN;
   wordT             imemAddr;
   wordT             imemData;
   logic             wbValid;
   proc_pkg::regIdxT wbReg;
   wordT             wbData;
   logic             halt;
   logic             err;

   wordT             prog [ProgLen];
   wordT             regFile [`PROC_NREGS];
   wordT             dataMem [2**`PROC_DMEM_AW];
   proc_pkg::regIdxT expReg [$];
   wordT             expData [$];
   logic             expHalt;
   logic             expErr;
   integer           seed = 32'hc2b0_ceb3;
   int               badIdx;

   proc proc_inst (.*);

   bind proc proc_sva procSva (.clk(clk), .rstN(rstN), .wbValid(wbValid),
                               .halt(halt), .err(err));

   // Instruction memory answers in the same cycle
   assign imemData = (imemAddr < ProgLen) ? prog[imemAddr] : NopWord;

   always #(ClkPeriod / 2) clk = ~clk;

   task automatic failNow(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic checkReg(input proc_pkg::regIdxT got, input proc_pkg::regIdxT exp);
      if (got !== exp)
         failNow($sformatf("Mismatch wbReg: got %h expected %h", got, exp));
   endtask

   task automatic checkData(input wordT got, input wordT exp);
      if (got !== exp)
         failNow($sformatf("Mismatch wbData: got %h expected %h", got, exp));
   endtask

   task automatic checkLevel(input string name, input logic got, input logic exp);
      if (got !== exp)
         failNow($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
   endtask

   function automatic wordT encR(input proc_pkg::opcodeE op, input proc_pkg::regIdxT rs,
                                 input proc_pkg::regIdxT rt, input proc_pkg::regIdxT rd,
                                 input logic [1:0] fn);
      return {op, rs, rt, rd, fn};
   endfunction

   function automatic wordT encI(input proc_pkg::opcodeE op, input proc_pkg::regIdxT rs,
                                 input proc_pkg::regIdxT rd, input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic wordT encB(input proc_pkg::opcodeE op, input proc_pkg::regIdxT rs,
                                 input logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   // Branches never pass limit, so the run always reaches the stop word
   task automatic genProgram(input int stopAt);
      int               pc;
      int               kind;
      int               limit;
      int               span;
      proc_pkg::regIdxT ra;
      proc_pkg::regIdxT rb;
      proc_pkg::regIdxT rc;
      proc_pkg::regIdxT lastRd;
      logic [1:0]       fn;
      logic [4:0]       imm5;
      logic [7:0]       imm8;
      logic [4:0]       badOp;
      logic [10:0]      rest;
      lastRd = '0;
      pc     = 0;
      while (pc < ProgLen - 1) begin
         limit = (pc < stopAt) ? stopAt : ProgLen - 1;
         kind  = $unsigned($random(seed)) % 10;
         ra    = $random(seed);
         rb    = $random(seed);
         rc    = $random(seed);
         fn    = $random(seed);
         imm5  = $random(seed);
         imm8  = $random(seed);
         // Half the time reuse the last destination for back-to-back use
         if ($random(seed) & 1)
            ra = lastRd;
         if (pc == stopAt) begin
            badOp    = 2 + $unsigned($random(seed)) % 6;
            rest     = $random(seed);
            prog[pc] = {badOp, rest};
         end else if (kind < 4) begin
            prog[pc] = encR(proc_pkg::OP_ALU, ra, rb, rc, fn);
            lastRd   = rc;
         end else if (kind == 4) begin
            prog[pc] = encI(proc_pkg::OP_ADDI, ra, rc, imm5);
            lastRd   = rc;
         end else if (kind == 5) begin
            prog[pc] = encB(proc_pkg::OP_LBI, rc, imm8);
            lastRd   = rc;
         end else if (kind == 6 && pc + 1 < limit) begin
            prog[pc] = encI(proc_pkg::OP_ST, ra, rb, imm5);
            pc++;
            prog[pc] = encI(proc_pkg::OP_LD, ra, rc, imm5);
            lastRd   = rc;
         end else if (kind == 7 && pc + 1 < limit) begin
            // Load-use pair
            prog[pc] = encI(proc_pkg::OP_LD, ra, rc, imm5);
            pc++;
            prog[pc] = encR(proc_pkg::OP_ALU, rc, rb, ra, fn);
            lastRd   = ra;
         end else if (kind == 8) begin
            span = limit - pc - 1;
            if (span > 7)
               span = 7;
            imm8     = $unsigned($random(seed)) % (span + 1);
            prog[pc] = encB(($random(seed) & 1) ? proc_pkg::OP_BEQZ : proc_pkg::OP_BNEZ,
                            ra, imm8);
         end else begin
            prog[pc] = NopWord;
         end
         pc++;
      end
      prog[ProgLen-1] = encB(proc_pkg::OP_HALT, '0, '0);
   endtask

   task automatic writeReg(input proc_pkg::regIdxT r, input wordT v);
      regFile[r] = v;
      expReg.push_back(r);
      expData.push_back(v);
   endtask

   // Architectural model that runs one instruction per step
   task automatic runModel();
      int                       pc;
      logic                     done;
      wordT                     w;
      wordT                     a;
      wordT                     b;
      wordT                     v;
      wordT                     imm5;
      wordT                     imm8;
      logic [`PROC_DMEM_AW-1:0] addr;
      foreach (regFile[k]) regFile[k] = '0;
      foreach (dataMem[k]) dataMem[k] = '0;
      expReg.delete();
      expData.delete();
      expHalt = 1'b0;
      expErr  = 1'b0;
      pc      = 0;
      done    = 1'b0;
      while (!done && pc < ProgLen) begin
         w    = prog[pc];
         a    = regFile[w[10:8]];
         b    = regFile[w[7:5]];
         imm5 = {{(`PROC_XLEN-5){w[4]}}, w[4:0]};
         imm8 = {{(`PROC_XLEN-8){w[7]}}, w[7:0]};
         addr = a + imm5;
         pc   = pc + 1;
         case (w[15:11])
            proc_pkg::OP_ALU: begin
               case (w[1:0])
                  proc_pkg::FN_ADD: v = a + b;
                  proc_pkg::FN_SUB: v = a - b;
                  proc_pkg::FN_XOR: v = a ^ b;
                  default:          v = a & b;
               endcase
               writeReg(w[4:2], v);
            end
            proc_pkg::OP_ADDI: writeReg(w[7:5], a + imm5);
            proc_pkg::OP_LBI:  writeReg(w[10:8], imm8);
            proc_pkg::OP_LD:   writeReg(w[7:5], dataMem[addr]);
            proc_pkg::OP_ST:   dataMem[addr] = b;
            proc_pkg::OP_BEQZ: if (a == '0) pc = pc + $signed(imm8);
            proc_pkg::OP_BNEZ: if (a != '0) pc = pc + $signed(imm8);
            proc_pkg::OP_NOP:  ;
            proc_pkg::OP_HALT: begin
               expHalt = 1'b1;
               done    = 1'b1;
            end
            default: begin
               expErr = 1'b1;
               done   = 1'b1;
            end
         endcase
      end
   endtask

   // New program loaded while reset is held
   task automatic runProgram(input int stopAt);
      @(posedge clk);
      #1 rstN = 1'b0;
      genProgram(stopAt);
      runModel();
      repeat (3) @(posedge clk);
      #1 rstN = 1'b1;
      checkLevel("halt", halt, 1'b0);
      checkLevel("err", err, 1'b0);
      while (!(halt || err))
         @(negedge clk);
      @(posedge clk);
      #1;
      if (expReg.size() != 0)
         failNow($sformatf("Core stopped with %0d register writes never retired",
                           expReg.size()));
      checkLevel("halt", halt, expHalt);
      checkLevel("err", err, expErr);
      repeat (8) @(posedge clk);
      #1;
      checkLevel("halt", halt, expHalt);
      checkLevel("err", err, expErr);
   endtask

   always @(negedge clk) begin
      if (rstN && wbValid) begin
         if (expReg.size() == 0) begin
            failNow("Register write retired that the model never made");
         end else begin
            checkReg(wbReg, expReg.pop_front());
            checkData(wbData, expData.pop_front());
         end
      end
   end

   always @(negedge clk) begin
      if (proc_inst.procSva.failCount != 0)
         failNow("A bound status assertion failed");
   end

   initial begin
      #(TimeoutCycles * ClkPeriod);
      failNow("Watchdog timeout, the core did not finish its programs in time");
   end

   initial begin
      clk  = 1'b0;
      rstN = 1'b0;
      foreach (prog[k]) prog[k] = NopWord;
      runProgram(-1);
      badIdx = 20 + $unsigned($random(seed)) % 32;
      runProgram(badIdx);
      @(posedge clk);
      #1 rstN = 1'b0;
      repeat (3) @(posedge clk);
      #1 rstN = 1'b1;
      checkLevel("halt", halt, 1'b0);
      checkLevel("err", err, 1'b0);
      if (proc_inst.procSva.failCount != 0) begin
         failNow("A bound status assertion failed");
      end else begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

// ==== compile.f ====
+incdir+logic
logic/proc_pkg.sv
logic/proc_if.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/memory.sv
logic/proc.sv
verif/proc_sva.sv
verif/proc_tb.sv
